//--- Makefile
# Verilator build and run for the MD cell store testbench

VERILATOR ?= verilator
TOP ?= md_cell_tb
FILELIST ?= filelist.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- filelist.f
verilog/md_cell_pkg.sv
verilog/cell_buffer_ram.sv
verilog/cell_cache.sv
verilog/particle_record_assembler.sv
verilog/md_cell_top.sv
verification/md_cell_checker.sv
verification/md_cell_tb.sv

//--- verification/md_cell_checker.sv
// Scoreboard for the MD cell store that models both cache banks and checks every record
`timescale 1ns/1ns
`default_nettype none

module md_cell_checker
#(
	parameter md_cell_pkg::cell_id_t CELL_X = 4'd4,
	parameter md_cell_pkg::cell_id_t CELL_Y = 4'd1,
	parameter md_cell_pkg::cell_id_t CELL_Z = 4'd3,
	parameter int PARTICLE_NUM = 220
)
(
	input wire clk,
	input wire rst,
	input wire update_en,
	input wire bc_valid,
	input wire md_cell_pkg::broadcast_t bc,
	input wire rd_en,
	input wire md_cell_pkg::particle_addr_t rd_addr,
	input wire rec_valid,
	input wire md_cell_pkg::particle_record_t rec,
	output int errors,
	output int checks,
	output int pending
);

	//////////////////////////////
	// Bank model
	//////////////////////////////

	// First index is the bank, word 0 holds the count
	md_cell_pkg::vec3_t pos_mem [0:1][0:255];
	md_cell_pkg::vec3_t vel_mem [0:1][0:255];
	// Bank that reads return, and its particle count
	int rd_bank;
	int rd_cnt;
	// Particles collected in the idle bank so far
	int wr_cnt;
	logic upd_q;
	longint cycle;

	// Expected records and the cycle each read was issued
	md_cell_pkg::particle_record_t exp_q[$];
	longint issue_q[$];

	// Both banks start empty
	initial
	begin
		for (int b = 0; b < 2; b++)
		begin
			for (int a = 0; a < 256; a++)
			begin
				pos_mem[b][a] = '0;
				vel_mem[b][a] = '0;
			end
		end
		rd_bank = 0;
		rd_cnt = 0;
		wr_cnt = 0;
		upd_q = 1'b0;
		cycle = 0;
		errors = 0;
		checks = 0;
		pending = 0;
	end

	// Count word: the count in the low bits of x, rest zero
	function automatic md_cell_pkg::vec3_t count_word(int n);
		md_cell_pkg::vec3_t v;
		v = '0;
		v.x = md_cell_pkg::coord_t'(n);
		return v;
	endfunction

	// Record that a read of address a should give from the readable bank
	function automatic md_cell_pkg::particle_record_t expect_read(md_cell_pkg::particle_addr_t a);
		md_cell_pkg::particle_record_t r;
		r.addr = a;
		r.count = (a == 8'd0);
		r.in_range = (a != 8'd0) && (int'(a) <= rd_cnt);
		r.pos = pos_mem[rd_bank][a];
		r.vel = vel_mem[rd_bank][a];
		return r;
	endfunction

	//////////////////////////////
	// Compare and update
	//////////////////////////////

	// Inputs and outputs are both settled at the falling edge
	always @(negedge clk)
	begin
		md_cell_pkg::particle_record_t exp_rec;
		longint issued;
		cycle++;
		if (!rst)
		begin
			// Output side first, a record belongs to a read two cycles back
			if (rec_valid)
			begin
				if (exp_q.size() == 0)
				begin
					errors++;
					$display("rec_valid high at %0t with no read outstanding", $time);
				end
				else
				begin
					exp_rec = exp_q.pop_front();
					issued = issue_q.pop_front();
					checks++;
					if (cycle != issued + 2)
					begin
						errors++;
						$display("Record at %0t came %0d cycles after its read instead of 2",
							$time, cycle - issued);
					end
					if (rec !== exp_rec)
					begin
						errors++;
						$display("ERROR %0t: got addr %0d cnt %0b rng %0b pos %h vel %h", $time,
							rec.addr, rec.count, rec.in_range, rec.pos, rec.vel);
						$display("ERROR %0t: exp addr %0d cnt %0b rng %0b pos %h vel %h", $time,
							exp_rec.addr, exp_rec.count, exp_rec.in_range, exp_rec.pos, exp_rec.vel);
					end
				end
			end
			else if ((issue_q.size() > 0) && (issue_q[0] + 2 <= cycle))
			begin
				// Record never showed up
				errors++;
				$display("No record at %0t for the read of addr %0d", $time, exp_q[0].addr);
				exp_rec = exp_q.pop_front();
				issued = issue_q.pop_front();
			end
			if (rd_en)
			begin
				exp_q.push_back(expect_read(rd_addr));
				issue_q.push_back(cycle);
			end
			// Matching particles fill the idle bank in arrival order, extras dropped
			if (update_en && bc_valid && (bc.dst.x == CELL_X) && (bc.dst.y == CELL_Y) &&
				(bc.dst.z == CELL_Z) && (wr_cnt < PARTICLE_NUM))
			begin
				wr_cnt++;
				pos_mem[1 - rd_bank][wr_cnt] = bc.pos;
				vel_mem[1 - rd_bank][wr_cnt] = bc.vel;
			end
			// End of update: count word, then the banks trade places
			if (upd_q && !update_en)
			begin
				pos_mem[1 - rd_bank][0] = count_word(wr_cnt);
				vel_mem[1 - rd_bank][0] = count_word(wr_cnt);
				rd_cnt = wr_cnt;
				rd_bank = 1 - rd_bank;
				wr_cnt = 0;
			end
			upd_q = update_en;
		end
		pending = exp_q.size();
	end

endmodule

`default_nettype wire

//--- verification/md_cell_tb.sv
// Testbench top for the MD cell store with seeded random broadcasts, reads and a timeout
`timescale 1ns/1ns
`default_nettype none

module md_cell_tb;

	localparam md_cell_pkg::cell_id_t CELL_X = 4'd4;
	localparam md_cell_pkg::cell_id_t CELL_Y = 4'd1;
	localparam md_cell_pkg::cell_id_t CELL_Z = 4'd3;
	localparam int PARTICLE_NUM = 220;
	localparam int ROUNDS = 12;
	// Round that overfills the bank
	localparam int FULL_ROUND = 5;
	localparam int MAX_BC = PARTICLE_NUM + 40;
	localparam int MAX_GAP = 3;
	// Longest round is the broadcasts with gaps, the idle gap, the sweep and a margin
	localparam int ROUND_LEN = MAX_BC * (MAX_GAP + 1) + 6 + PARTICLE_NUM + 1 + 4;
	localparam int LIMIT = 16 + 20 + ROUNDS * ROUND_LEN + 2000;

	logic clk;
	logic rst;
	logic update_en;
	logic bc_valid;
	md_cell_pkg::broadcast_t bc;
	logic rd_en;
	md_cell_pkg::particle_addr_t rd_addr;
	logic rec_valid;
	md_cell_pkg::particle_record_t rec;
	int errors;
	int checks;
	int pending;
	int cycles;

	md_cell_top
	#(
		.CELL_X(CELL_X),
		.CELL_Y(CELL_Y),
		.CELL_Z(CELL_Z),
		.PARTICLE_NUM(PARTICLE_NUM)
	)
	uut
	(
		.clk(clk),
		.rst(rst),
		.update_en(update_en),
		.bc_valid(bc_valid),
		.bc(bc),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.rec_valid(rec_valid),
		.rec(rec)
	);

	md_cell_checker
	#(
		.CELL_X(CELL_X),
		.CELL_Y(CELL_Y),
		.CELL_Z(CELL_Z),
		.PARTICLE_NUM(PARTICLE_NUM)
	)
	scoreboard
	(
		.clk(clk),
		.rst(rst),
		.update_en(update_en),
		.bc_valid(bc_valid),
		.bc(bc),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.rec_valid(rec_valid),
		.rec(rec),
		.errors(errors),
		.checks(checks),
		.pending(pending)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Hard stop if the run overstays its worst-case length
	initial
	begin
		cycles = 0;
		while (cycles < LIMIT)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: run still going after %0d cycles", cycles);
		$display("SOME TESTS FAILED");
		$finish;
	end

	// Next drive point, just after the rising edge
	task automatic step();
		@(posedge clk);
		#1;
	endtask

	// Read strobe in about one cycle out of four
	task automatic maybe_read();
		rd_en = ($urandom_range(3, 0) == 0);
		rd_addr = md_cell_pkg::particle_addr_t'($urandom_range(PARTICLE_NUM, 0));
	endtask

	// Random particle for this cell or for some other one
	task automatic load_broadcast(bit own);
		int axis;
		bc.pos = {$urandom(), $urandom(), $urandom()};
		bc.vel = {$urandom(), $urandom(), $urandom()};
		bc.dst = '{x: CELL_X, y: CELL_Y, z: CELL_Z};
		if (!own)
		begin
			axis = $urandom_range(3, 0);
			// Mostly one index off, so each axis compare of the filter matters
			if (axis == 0)
			begin
				bc.dst.x = CELL_X ^ md_cell_pkg::cell_id_t'($urandom_range(15, 1));
			end
			else if (axis == 1)
			begin
				bc.dst.y = CELL_Y ^ md_cell_pkg::cell_id_t'($urandom_range(15, 1));
			end
			else if (axis == 2)
			begin
				bc.dst.z = CELL_Z ^ md_cell_pkg::cell_id_t'($urandom_range(15, 1));
			end
			else
			begin
				// Anywhere else in the grid
				bc.dst = md_cell_pkg::cell_addr_t'($urandom_range(4095, 0));
				if ((bc.dst.x == CELL_X) && (bc.dst.y == CELL_Y) && (bc.dst.z == CELL_Z))
				begin
					bc.dst.z = ~CELL_Z;
				end
			end
		end
	endtask

	// One motion update with reads mixed in, then the idle gap
	task automatic run_update(int n_bc, int own_pct, int max_gap);
		int gap;
		update_en = 1'b1;
		for (int i = 0; i < n_bc; i++)
		begin
			gap = $urandom_range(max_gap, 0);
			for (int g = 0; g < gap; g++)
			begin
				bc_valid = 1'b0;
				maybe_read();
				step();
			end
			bc_valid = 1'b1;
			load_broadcast($urandom_range(99, 0) < own_pct);
			maybe_read();
			step();
		end
		update_en = 1'b0;
		bc_valid = 1'b0;
		rd_en = 1'b0;
		repeat (6) step();
	endtask

	// Back-to-back reads of the count and every particle slot
	task automatic sweep();
		for (int a = 0; a <= PARTICLE_NUM; a++)
		begin
			rd_en = 1'b1;
			rd_addr = md_cell_pkg::particle_addr_t'(a);
			step();
		end
		rd_en = 1'b0;
		step();
	endtask

	initial
	begin
		int fails;
		void'($urandom(32'h9e76_cb61));
		rst = 1'b1;
		update_en = 1'b0;
		bc_valid = 1'b0;
		bc = '0;
		rd_en = 1'b0;
		rd_addr = '0;
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;
		// Fresh banks read quiet first, then count 0 at address 0
		repeat (4) step();
		for (int a = 0; a < 3; a++)
		begin
			rd_en = 1'b1;
			rd_addr = md_cell_pkg::particle_addr_t'(a);
			step();
		end
		rd_en = 1'b0;
		repeat (4) step();
		for (int r = 0; r < ROUNDS; r++)
		begin
			if (r == FULL_ROUND)
				run_update(PARTICLE_NUM + 30, 100, 1);
			else
				run_update($urandom_range(80, 20), 50, MAX_GAP);
			sweep();
		end
		repeat (4) step();
		fails = errors;
		if (pending != 0)
		begin
			$display("Reads still waiting for a record at the end: %0d", pending);
			fails++;
		end
		$display("Records checked: %0d, errors: %0d", checks, fails);
		if (fails == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/cell_buffer_ram.sv
// Cell bank RAM, single port, registered address and output, two-cycle read
`timescale 1ns/1ns
`default_nettype none

module cell_buffer_ram
#(
	parameter int WIDTH = 96,
	parameter int DEPTH = 221
)
(
	input wire clk,
	input wire md_cell_pkg::particle_addr_t addr,
	input wire wr_en,
	input wire [WIDTH-1:0] wr_data,
	input wire rd_en,
	output logic [WIDTH-1:0] rd_data
);

	// Storage array, word 0 is the particle count
	logic [WIDTH-1:0] mem [0:DEPTH-1];

	// Read address stage
	md_cell_pkg::particle_addr_t addr_q;
	logic rd_en_q;

	// Empty bank at power-up, so address 0 reads as count 0
	initial
	begin
		for (int i = 0; i < DEPTH; i++)
		begin
			mem[i] = '0;
		end
		addr_q = '0;
		rd_en_q = 1'b0;
		rd_data = '0;
	end

	always @(posedge clk)
	begin
		// Write goes straight in, the caller already registered it
		if (wr_en)
		begin
			mem[addr] <= wr_data;
		end
		// First read cycle: capture the address
		if (rd_en)
		begin
			addr_q <= addr;
		end
		rd_en_q <= rd_en;
		// Second read cycle: output register, holds between reads
		if (rd_en_q)
		begin
			rd_data <= mem[addr_q];
		end
	end

endmodule

`default_nettype wire

//--- verilog/cell_cache.sv
// Double-buffered cell cache that filters broadcasts by cell and swaps banks per update
`timescale 1ns/1ns
`default_nettype none

module cell_cache
#(
	parameter md_cell_pkg::cell_id_t CELL_X = 4'd0,
	parameter md_cell_pkg::cell_id_t CELL_Y = 4'd0,
	parameter md_cell_pkg::cell_id_t CELL_Z = 4'd0,
	parameter int PARTICLE_NUM = 220
)
(
	input wire clk,
	input wire rst,
	input wire update_en,
	input wire bc_valid,
	input wire md_cell_pkg::vec3_t bc_vec,
	input wire md_cell_pkg::cell_addr_t bc_dst,
	input wire rd_en,
	input wire md_cell_pkg::particle_addr_t rd_addr,
	output md_cell_pkg::vec3_t rd_data,
	output md_cell_pkg::particle_addr_t rd_count
);

	// One extra word for the count at address 0
	localparam int DEPTH = PARTICLE_NUM + 1;

	//////////////////////////////
	// Destination filter
	//////////////////////////////

	md_cell_pkg::cache_state_t state;
	// Bank holding last step's data, the other one collects
	logic active;
	// Particles written so far in this update
	md_cell_pkg::particle_addr_t arr_count;
	logic match;
	logic accept;

	// Only broadcasts for this cell during an update
	assign match = bc_valid && update_en && (bc_dst.x == CELL_X) &&
		(bc_dst.y == CELL_Y) && (bc_dst.z == CELL_Z);

	// Drop when full, and never outside the collect window
	assign accept = match && (arr_count < PARTICLE_NUM) &&
		((state == md_cell_pkg::idle) || (state == md_cell_pkg::collect));

	//////////////////////////////
	// Control FSM
	//////////////////////////////

	// Registered bank write
	logic wr_en;
	md_cell_pkg::particle_addr_t wr_addr;
	md_cell_pkg::vec3_t wr_data;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= md_cell_pkg::idle;
			active <= 1'b0;
			arr_count <= '0;
			wr_en <= 1'b0;
			rd_count <= '0;
		end
		else
		begin
			wr_en <= accept;
			if (accept)
			begin
				arr_count <= arr_count + 8'd1;
			end
			case (state)
				// First cycle with update_en may already carry a particle
				md_cell_pkg::idle:
				begin
					if (update_en)
					begin
						state <= md_cell_pkg::collect;
					end
				end
				md_cell_pkg::collect:
				begin
					if (!update_en)
					begin
						state <= md_cell_pkg::write_count;
					end
				end
				// Count goes to address 0 of the idle bank
				md_cell_pkg::write_count:
				begin
					wr_en <= 1'b1;
					state <= md_cell_pkg::swap;
				end
				// Count write lands on this edge, then the banks trade roles
				md_cell_pkg::swap:
				begin
					active <= ~active;
					rd_count <= arr_count;
					arr_count <= '0;
					state <= md_cell_pkg::idle;
				end
				default:
				begin
					state <= md_cell_pkg::idle;
				end
			endcase
		end
	end

	// Write address and data
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			wr_addr <= arr_count + 8'd1;
			wr_data <= bc_vec;
		end
		else if (state == md_cell_pkg::write_count)
		begin
			wr_addr <= '0;
			// Count in the low bits of x
			wr_data <= '{z: '0, y: '0, x: md_cell_pkg::coord_t'(arr_count)};
		end
	end

	//////////////////////////////
	// Bank steering
	//////////////////////////////

	md_cell_pkg::particle_addr_t b0_addr;
	md_cell_pkg::particle_addr_t b1_addr;
	logic b0_wr_en;
	logic b1_wr_en;
	logic b0_rd_en;
	logic b1_rd_en;
	md_cell_pkg::vec3_t b0_q;
	md_cell_pkg::vec3_t b1_q;
	// Flag delayed to line up with the RAM output
	logic act_d1;
	logic act_d2;

	// Reads hit the active bank, writes the other one
	assign b0_addr = active ? wr_addr : rd_addr;
	assign b1_addr = active ? rd_addr : wr_addr;
	assign b0_wr_en = active & wr_en;
	assign b1_wr_en = ~active & wr_en;
	assign b0_rd_en = ~active & rd_en;
	assign b1_rd_en = active & rd_en;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			act_d1 <= 1'b0;
			act_d2 <= 1'b0;
		end
		else
		begin
			act_d1 <= active;
			act_d2 <= act_d1;
		end
	end

	assign rd_data = act_d2 ? b1_q : b0_q;

	cell_buffer_ram
	#(
		.WIDTH($bits(md_cell_pkg::vec3_t)),
		.DEPTH(DEPTH)
	)
	bank_0
	(
		.clk(clk),
		.addr(b0_addr),
		.wr_en(b0_wr_en),
		.wr_data(wr_data),
		.rd_en(b0_rd_en),
		.rd_data(b0_q)
	);

	cell_buffer_ram
	#(
		.WIDTH($bits(md_cell_pkg::vec3_t)),
		.DEPTH(DEPTH)
	)
	bank_1
	(
		.clk(clk),
		.addr(b1_addr),
		.wr_en(b1_wr_en),
		.wr_data(wr_data),
		.rd_en(b1_rd_en),
		.rd_data(b1_q)
	);

	//////////////////////////////
	// Assertions
	//////////////////////////////

	// Update rounds must leave room for the count write and the swap
	a_no_bc_when_busy: assert property (@(posedge clk) disable iff (rst)
		((state == md_cell_pkg::write_count) || (state == md_cell_pkg::swap)) |-> !bc_valid)
		else $error("broadcast during count write or swap");

	// Address 0 belongs to the count, written only out of write_count
	a_addr0_only_count: assert property (@(posedge clk) disable iff (rst)
		(wr_en && (wr_addr == '0)) |-> ($past(state) == md_cell_pkg::write_count))
		else $error("particle write to address 0");

endmodule

`default_nettype wire

//--- verilog/md_cell_pkg.sv
// MD cell store package with the coordinate, address, broadcast and record types
`default_nettype none

package md_cell_pkg;

	//////////////////////////////
	// Scalar types
	//////////////////////////////

	// Fixed-point coordinate or velocity component
	typedef logic [31:0] coord_t;

	// One axis index of a cell in the grid
	typedef logic [3:0] cell_id_t;

	// Word address inside one cell bank
	// Address 0 holds the particle count, particles start at 1
	typedef logic [7:0] particle_addr_t;

	//////////////////////////////
	// Packed structs
	//////////////////////////////

	// Three components, z on top, 96 bits
	typedef struct packed
	{
		coord_t z;
		coord_t y;
		coord_t x;
	} vec3_t;

	// Cell address, x on top, 12 bits
	typedef struct packed
	{
		cell_id_t x;
		cell_id_t y;
		cell_id_t z;
	} cell_addr_t;

	// One moved particle on the broadcast bus, 204 bits
	typedef struct packed
	{
		vec3_t pos;
		vec3_t vel;
		cell_addr_t dst;
	} broadcast_t;

	// Assembled readout of one cell address, 202 bits
	typedef struct packed
	{
		particle_addr_t addr;
		logic in_range;
		logic count;
		vec3_t pos;
		vec3_t vel;
	} particle_record_t;

	// Cache control FSM
	typedef enum logic [1:0]
	{
		idle,
		collect,
		write_count,
		swap
	} cache_state_t;

endpackage

`default_nettype wire

//--- verilog/md_cell_top.sv
// MD cell top with position cache, velocity cache and record assembler
`timescale 1ns/1ns
`default_nettype none

module md_cell_top
#(
	parameter md_cell_pkg::cell_id_t CELL_X = 4'd4,
	parameter md_cell_pkg::cell_id_t CELL_Y = 4'd1,
	parameter md_cell_pkg::cell_id_t CELL_Z = 4'd3,
	parameter int PARTICLE_NUM = 220
)
(
	input wire clk,
	input wire rst,
	input wire update_en,
	input wire bc_valid,
	input wire md_cell_pkg::broadcast_t bc,
	input wire rd_en,
	input wire md_cell_pkg::particle_addr_t rd_addr,
	output logic rec_valid,
	output md_cell_pkg::particle_record_t rec
);

	//////////////////////////////
	// Cache readouts
	//////////////////////////////

	md_cell_pkg::vec3_t pos_rd_data;
	md_cell_pkg::vec3_t vel_rd_data;
	md_cell_pkg::particle_addr_t pos_rd_count;

	// Position half of the store
	cell_cache
	#(
		.CELL_X(CELL_X),
		.CELL_Y(CELL_Y),
		.CELL_Z(CELL_Z),
		.PARTICLE_NUM(PARTICLE_NUM)
	)
	pos_cache
	(
		.clk(clk),
		.rst(rst),
		.update_en(update_en),
		.bc_valid(bc_valid),
		.bc_vec(bc.pos),
		.bc_dst(bc.dst),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.rd_data(pos_rd_data),
		.rd_count(pos_rd_count)
	);

	// Velocity half, same arrivals, so its count is a copy
	cell_cache
	#(
		.CELL_X(CELL_X),
		.CELL_Y(CELL_Y),
		.CELL_Z(CELL_Z),
		.PARTICLE_NUM(PARTICLE_NUM)
	)
	vel_cache
	(
		.clk(clk),
		.rst(rst),
		.update_en(update_en),
		.bc_valid(bc_valid),
		.bc_vec(bc.vel),
		.bc_dst(bc.dst),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.rd_data(vel_rd_data),
		.rd_count()
	);

	particle_record_assembler
	#(
		.PARTICLE_NUM(PARTICLE_NUM)
	)
	assembler
	(
		.clk(clk),
		.rst(rst),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.pos_data(pos_rd_data),
		.vel_data(vel_rd_data),
		.rd_count(pos_rd_count),
		.rec_valid(rec_valid),
		.rec(rec)
	);

endmodule

`default_nettype wire

//--- verilog/particle_record_assembler.sv
// Record assembler that merges position and velocity readouts and flags valid particles
`timescale 1ns/1ns
`default_nettype none

module particle_record_assembler
#(
	parameter int PARTICLE_NUM = 220
)
(
	input wire clk,
	input wire rst,
	input wire rd_en,
	input wire md_cell_pkg::particle_addr_t rd_addr,
	input wire md_cell_pkg::vec3_t pos_data,
	input wire md_cell_pkg::vec3_t vel_data,
	input wire md_cell_pkg::particle_addr_t rd_count,
	output logic rec_valid,
	output md_cell_pkg::particle_record_t rec
);

	//////////////////////////////
	// Request pipeline
	//////////////////////////////

	// Stage 1 matches the RAM address register
	logic v1;
	md_cell_pkg::particle_addr_t a1;
	md_cell_pkg::particle_addr_t c1;
	// Stage 2 matches the RAM output register
	md_cell_pkg::particle_addr_t a2;
	md_cell_pkg::particle_addr_t c2;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			v1 <= 1'b0;
			rec_valid <= 1'b0;
		end
		else
		begin
			v1 <= rd_en;
			rec_valid <= v1;
		end
	end

	// Count taken at request time, so it matches the bank that was read
	always_ff @(posedge clk)
	begin
		a1 <= rd_addr;
		c1 <= rd_count;
		a2 <= a1;
		c2 <= c1;
	end

	//////////////////////////////
	// Record packing
	//////////////////////////////

	always_comb
	begin
		rec.addr = a2;
		rec.count = (a2 == '0);
		// Real particle: past the count word, within count and bank depth
		rec.in_range = (a2 != '0) && (a2 <= c2) && (a2 <= PARTICLE_NUM);
		rec.pos = pos_data;
		rec.vel = vel_data;
	end

	// Both caches see the same arrivals, so their counts agree
	a_count_words_agree: assert property (@(posedge clk) disable iff (rst)
		(rec_valid && rec.count) |->
		(md_cell_pkg::particle_addr_t'(pos_data.x) == md_cell_pkg::particle_addr_t'(vel_data.x)))
		else $error("position and velocity counts differ");

endmodule

`default_nettype wire
